// ==== source/bp_pkg.sv ====
package bp_pkg;

    // pc and target width, word addressed
    localparam int ADDR_WIDTH = 30;
    typedef logic [ADDR_WIDTH-1:0] addr_t;

    // kind table
    localparam int KT_ENTRIES = 64;
    localparam int KT_IDX_W   = 6;

    // bimodal and chooser tables share one size
    localparam int BIM_ENTRIES = 64;
    localparam int BIM_IDX_W   = 6;

    localparam int GH_WIDTH = 8;
    typedef logic [GH_WIDTH-1:0] gh_t;

    localparam int GSH_ENTRIES = 256;
    localparam int GSH_IDX_W   = 8;   // low pc bits xor history

    // btb, tag sits right above the index bits
    localparam int BTB_ENTRIES = 32;
    localparam int BTB_IDX_W   = 5;
    localparam int BTB_TAG_W   = 8;

    localparam int RAS_DEPTH = 8;
    localparam int RAS_PTR_W = 3;

    typedef logic [1:0] ctr_t;
    localparam ctr_t CTR_INIT = 2'd1;   // weakly not taken / prefer bimodal

    localparam addr_t RESET_PC = 30'h0700_0000;

    typedef logic [31:0] stat_t;

    typedef enum logic [2:0] {
        NOT_JUMP      = 3'd0,
        DIRECT_JUMP   = 3'd1,   // conditional direct branch
        RET           = 3'd4,
        INDIRECT_JUMP = 3'd5,
        CALL          = 3'd6,
        JUMP          = 3'd7
    } branch_kind_e;

endpackage

// ==== source/bp_update_if.sv ====
`timescale 1ns/1ps

// resolved branch info from execute, written into all tables
interface bp_update_if;

    logic                 valid;
    bp_pkg::addr_t        pc;
    bp_pkg::branch_kind_e kind;
    logic                 taken;
    bp_pkg::addr_t        target;
    logic                 mispredict;

    modport source (
        output valid,
        output pc,
        output kind,
        output taken,
        output target,
        output mispredict
    );

    modport tables (
        input valid,
        input pc,
        input kind,
        input taken,
        input target,
        input mispredict
    );

endinterface

// ==== source/kind_table.sv ====
`timescale 1ns/1ps

module kind_table (
    input  logic                 clk,
    input  logic                 rstn,
    input  logic                 stall,
    input  logic                 req_valid,
    input  bp_pkg::addr_t        pc,
    bp_update_if.tables          upd,
    output bp_pkg::branch_kind_e kind
);

    bp_pkg::branch_kind_e kt_mem [bp_pkg::KT_ENTRIES];

    logic [bp_pkg::KT_IDX_W-1:0] rd_idx;
    logic [bp_pkg::KT_IDX_W-1:0] wr_idx;
    logic                        req_fire;

    assign rd_idx   = pc[bp_pkg::KT_IDX_W-1:0];
    assign wr_idx   = upd.pc[bp_pkg::KT_IDX_W-1:0];
    assign req_fire = !stall && req_valid;

    // every entry starts out as a plain instruction
    always_ff @(posedge clk) begin
        if (!rstn) begin
            for (int i = 0; i < bp_pkg::KT_ENTRIES; i++) begin
                kt_mem[i] <= bp_pkg::NOT_JUMP;
            end
        end else if (upd.valid) begin
            kt_mem[wr_idx] <= upd.kind;
        end
    end

    // read before write on a same-entry collision
    always_ff @(posedge clk) begin
        if (!rstn) begin
            kind <= bp_pkg::NOT_JUMP;
        end else if (req_fire) begin
            kind <= kt_mem[rd_idx];
        end
    end

endmodule

// ==== source/direction_predictor.sv ====
`timescale 1ns/1ps

module direction_predictor (
    input  logic          clk,
    input  logic          rstn,
    input  logic          stall,
    input  logic          req_valid,
    input  bp_pkg::addr_t pc,
    bp_update_if.tables   upd,
    output logic          taken,
    output logic          use_gshare
);

    bp_pkg::ctr_t bim_tbl [bp_pkg::BIM_ENTRIES];
    bp_pkg::ctr_t cho_tbl [bp_pkg::BIM_ENTRIES];
    bp_pkg::ctr_t gsh_tbl [bp_pkg::GSH_ENTRIES];
    bp_pkg::gh_t  ghr;

    logic [bp_pkg::BIM_IDX_W-1:0] rd_bim_idx;
    logic [bp_pkg::GSH_IDX_W-1:0] rd_gsh_idx;
    logic [bp_pkg::BIM_IDX_W-1:0] up_bim_idx;
    logic [bp_pkg::GSH_IDX_W-1:0] up_gsh_idx;

    bp_pkg::ctr_t up_bim;
    bp_pkg::ctr_t up_gsh;
    bp_pkg::ctr_t up_cho;

    logic req_fire;
    logic pick_gsh;
    logic rd_taken;
    logic cond_upd;
    logic bim_ok;
    logic gsh_ok;

    // saturating step toward the outcome
    function automatic bp_pkg::ctr_t ctr_step(input bp_pkg::ctr_t c, input logic up);
        bp_pkg::ctr_t r;
        r = c;
        if (up && c != 2'd3) begin
            r = c + 2'd1;
        end else if (!up && c != 2'd0) begin
            r = c - 2'd1;
        end
        return r;
    endfunction

    assign req_fire = !stall && req_valid;

    assign rd_bim_idx = pc[bp_pkg::BIM_IDX_W-1:0];
    assign rd_gsh_idx = pc[bp_pkg::GSH_IDX_W-1:0] ^ ghr;

    assign pick_gsh = cho_tbl[rd_bim_idx][1];
    assign rd_taken = pick_gsh ? gsh_tbl[rd_gsh_idx][1] : bim_tbl[rd_bim_idx][1];

    // update side uses the committed history, before it shifts
    assign up_bim_idx = upd.pc[bp_pkg::BIM_IDX_W-1:0];
    assign up_gsh_idx = upd.pc[bp_pkg::GSH_IDX_W-1:0] ^ ghr;

    assign up_bim = bim_tbl[up_bim_idx];
    assign up_gsh = gsh_tbl[up_gsh_idx];
    assign up_cho = cho_tbl[up_bim_idx];

    assign cond_upd = upd.valid && (upd.kind == bp_pkg::DIRECT_JUMP);
    assign bim_ok   = (up_bim[1] == upd.taken);
    assign gsh_ok   = (up_gsh[1] == upd.taken);

    always_ff @(posedge clk) begin
        if (!rstn) begin
            for (int i = 0; i < bp_pkg::BIM_ENTRIES; i++) begin
                bim_tbl[i] <= bp_pkg::CTR_INIT;
                cho_tbl[i] <= bp_pkg::CTR_INIT;
            end
        end else if (cond_upd) begin
            bim_tbl[up_bim_idx] <= ctr_step(up_bim, upd.taken);
            // chooser only learns when the two tables disagree on correctness
            if (bim_ok != gsh_ok) begin
                cho_tbl[up_bim_idx] <= ctr_step(up_cho, gsh_ok);
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!rstn) begin
            for (int i = 0; i < bp_pkg::GSH_ENTRIES; i++) begin
                gsh_tbl[i] <= bp_pkg::CTR_INIT;
            end
        end else if (cond_upd) begin
            gsh_tbl[up_gsh_idx] <= ctr_step(up_gsh, upd.taken);
        end
    end

    // non-speculative history
    always_ff @(posedge clk) begin
        if (!rstn) begin
            ghr <= '0;
        end else if (cond_upd) begin
            ghr <= {ghr[bp_pkg::GH_WIDTH-2:0], upd.taken};
        end
    end

    always_ff @(posedge clk) begin
        if (!rstn) begin
            taken      <= 1'b0;
            use_gshare <= 1'b0;
        end else if (req_fire) begin
            taken      <= rd_taken;
            use_gshare <= pick_gsh;
        end
    end

endmodule

// ==== source/target_predictor.sv ====
`timescale 1ns/1ps

module target_predictor (
    input  logic                 clk,
    input  logic                 rstn,
    input  logic                 stall,
    input  logic                 req_valid,
    input  bp_pkg::addr_t        pc,
    input  bp_pkg::branch_kind_e kind,
    input  logic                 taken,
    bp_update_if.tables          upd,
    output bp_pkg::addr_t        npc
);

    logic [bp_pkg::BTB_TAG_W-1:0] btb_tag [bp_pkg::BTB_ENTRIES];
    bp_pkg::addr_t                btb_tgt [bp_pkg::BTB_ENTRIES];
    logic [bp_pkg::BTB_ENTRIES-1:0] btb_vld;

    bp_pkg::addr_t                ras_mem [bp_pkg::RAS_DEPTH];
    logic [bp_pkg::RAS_PTR_W-1:0] ras_ptr;
    logic [bp_pkg::RAS_PTR_W-1:0] top_ptr;
    logic [bp_pkg::RAS_PTR_W:0]   ras_cnt;
    bp_pkg::addr_t                ras_top;

    logic [bp_pkg::BTB_IDX_W-1:0] rd_idx;
    logic [bp_pkg::BTB_TAG_W-1:0] rd_tag;
    logic [bp_pkg::BTB_IDX_W-1:0] wr_idx;
    logic                         btb_wr;

    bp_pkg::addr_t pc_q;
    bp_pkg::addr_t tgt_q;
    bp_pkg::addr_t npc_sel;
    logic          hit_q;
    logic          valid_q;
    logic          ras_push;
    logic          ras_pop;

    assign rd_idx = pc[bp_pkg::BTB_IDX_W-1:0];
    assign rd_tag = pc[bp_pkg::BTB_IDX_W +: bp_pkg::BTB_TAG_W];
    assign wr_idx = upd.pc[bp_pkg::BTB_IDX_W-1:0];
    assign btb_wr = upd.valid && upd.taken && (upd.kind != bp_pkg::NOT_JUMP);

    always_ff @(posedge clk) begin
        if (!rstn) begin
            btb_vld <= '0;
        end else if (btb_wr) begin
            btb_vld[wr_idx] <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (btb_wr) begin
            btb_tag[wr_idx] <= upd.pc[bp_pkg::BTB_IDX_W +: bp_pkg::BTB_TAG_W];
            btb_tgt[wr_idx] <= upd.target;
        end
    end

    // lookup captured on the request edge
    always_ff @(posedge clk) begin
        if (!rstn) begin
            pc_q    <= bp_pkg::RESET_PC;
            hit_q   <= 1'b0;
            valid_q <= 1'b0;
        end else if (!stall) begin
            valid_q <= req_valid;
            if (req_valid) begin
                pc_q  <= pc;
                hit_q <= btb_vld[rd_idx] && (btb_tag[rd_idx] == rd_tag);
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!stall && req_valid) begin
            tgt_q <= btb_tgt[rd_idx];
        end
    end

    // stack action of the held prediction lands on the next request edge
    assign ras_push = !stall && valid_q && (kind == bp_pkg::CALL);
    assign ras_pop  = !stall && valid_q && (kind == bp_pkg::RET);

    always_ff @(posedge clk) begin
        if (!rstn) begin
            ras_ptr <= '0;
            ras_cnt <= '0;
        end else if (ras_push) begin
            ras_ptr <= ras_ptr + 1'b1;  // wraps over the oldest when full
            if (ras_cnt != bp_pkg::RAS_DEPTH) ras_cnt <= ras_cnt + 1'b1;
        end else if (ras_pop && ras_cnt != '0) begin
            ras_ptr <= top_ptr;
            ras_cnt <= ras_cnt - 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (ras_push) begin
            ras_mem[ras_ptr] <= pc_q + 1'b1;
        end
    end

    assign top_ptr = ras_ptr - 1'b1;
    assign ras_top = (ras_cnt == '0) ? '0 : ras_mem[top_ptr];

    always_comb begin
        npc_sel = pc_q + 1'b1;
        case (kind)
            bp_pkg::RET: npc_sel = ras_top;
            bp_pkg::JUMP, bp_pkg::CALL, bp_pkg::INDIRECT_JUMP: begin
                if (hit_q) npc_sel = tgt_q;
            end
            bp_pkg::DIRECT_JUMP: begin
                if (hit_q && taken) npc_sel = tgt_q;
            end
            default: npc_sel = pc_q + 1'b1;
        endcase
    end

    assign npc = valid_q ? npc_sel : pc_q;  // reset pc until first request

endmodule

// ==== source/predictor.sv ====
`timescale 1ns/1ps

module predictor (
    input  logic                 clk,
    input  logic                 rstn,
    input  logic                 stall,
    input  logic                 req_valid,
    input  bp_pkg::addr_t        pc,
    input  logic                 upd_valid,
    input  bp_pkg::addr_t        upd_pc,
    input  bp_pkg::branch_kind_e upd_kind,
    input  logic                 upd_taken,
    input  bp_pkg::addr_t        upd_target,
    input  logic                 upd_mispredict,
    output logic                 pred_valid,
    output bp_pkg::addr_t        pred_npc,
    output bp_pkg::branch_kind_e pred_kind,
    output logic                 pred_taken,
    output logic                 pred_use_gshare,
    output bp_pkg::stat_t        stat_updates,
    output bp_pkg::stat_t        stat_mispredicts
);

    bp_update_if upd_if ();

    // execute stage update, fanned out to every table
    assign upd_if.valid      = upd_valid;
    assign upd_if.pc         = upd_pc;
    assign upd_if.kind       = upd_kind;
    assign upd_if.taken      = upd_taken;
    assign upd_if.target     = upd_target;
    assign upd_if.mispredict = upd_mispredict;

    always_ff @(posedge clk) begin
        if (!rstn) begin
            pred_valid <= 1'b0;
        end else if (!stall) begin
            pred_valid <= req_valid;
        end
    end

    kind_table u_kind_table (
        .clk       (clk),
        .rstn      (rstn),
        .stall     (stall),
        .req_valid (req_valid),
        .pc        (pc),
        .upd       (upd_if),
        .kind      (pred_kind)
    );

    direction_predictor u_direction_predictor (
        .clk        (clk),
        .rstn       (rstn),
        .stall      (stall),
        .req_valid  (req_valid),
        .pc         (pc),
        .upd        (upd_if),
        .taken      (pred_taken),
        .use_gshare (pred_use_gshare)
    );

    target_predictor u_target_predictor (
        .clk       (clk),
        .rstn      (rstn),
        .stall     (stall),
        .req_valid (req_valid),
        .pc        (pc),
        .kind      (pred_kind),
        .taken     (pred_taken),
        .upd       (upd_if),
        .npc       (pred_npc)
    );

    // statistics, counted regardless of stall
    always_ff @(posedge clk) begin
        if (!rstn) begin
            stat_updates     <= '0;
            stat_mispredicts <= '0;
        end else if (upd_if.valid) begin
            stat_updates <= stat_updates + 1'b1;
            if (upd_if.mispredict) stat_mispredicts <= stat_mispredicts + 1'b1;
        end
    end

endmodule

// ==== verif/predictor_checker.sv ====
`timescale 1ns/1ps

module predictor_checker (
    input logic                 clk,
    input logic                 rstn,
    input logic                 stall,
    input logic                 pred_valid,
    input bp_pkg::addr_t        pred_npc,
    input bp_pkg::branch_kind_e pred_kind,
    input logic                 pred_taken,
    input logic                 pred_use_gshare,
    input bp_pkg::stat_t        stat_updates,
    input bp_pkg::stat_t        stat_mispredicts
);

    property valid_low_after_reset;
        @(posedge clk) !rstn |=> !pred_valid;
    endproperty

    // a stalled edge freezes the whole prediction
    property hold_on_stall;
        @(posedge clk) disable iff (!rstn)
            stall |=> $stable(pred_valid) && $stable(pred_npc) && $stable(pred_kind)
                && $stable(pred_taken) && $stable(pred_use_gshare);
    endproperty

    property kind_legal;
        @(posedge clk) disable iff (!rstn)
            pred_kind inside {bp_pkg::NOT_JUMP, bp_pkg::DIRECT_JUMP, bp_pkg::RET,
                              bp_pkg::INDIRECT_JUMP, bp_pkg::CALL, bp_pkg::JUMP};
    endproperty

    property mispredicts_bounded;
        @(posedge clk) disable iff (!rstn) stat_mispredicts <= stat_updates;
    endproperty

    assert property (valid_low_after_reset) else $error("pred_valid high after reset");
    assert property (hold_on_stall) else $error("prediction changed across a stall");
    assert property (kind_legal) else $error("pred_kind holds an illegal code");
    assert property (mispredicts_bounded) else $error("more mispredicts than updates");

endmodule

// ==== verif/tb_predictor.sv ====
`timescale 1ns/1ps

module tb_predictor;

    localparam int NCOL       = 14;   // columns per vector line
    localparam int MAX_VEC    = 64;
    localparam int RST_CYCLES = 4;

    logic                 clk;
    logic                 rstn;
    logic                 stall;
    logic                 req_valid;
    bp_pkg::addr_t        pc;
    logic                 upd_valid;
    bp_pkg::addr_t        upd_pc;
    bp_pkg::branch_kind_e upd_kind;
    logic                 upd_taken;
    bp_pkg::addr_t        upd_target;
    logic                 upd_mispredict;
    logic                 pred_valid;
    bp_pkg::addr_t        pred_npc;
    bp_pkg::branch_kind_e pred_kind;
    logic                 pred_taken;
    logic                 pred_use_gshare;
    bp_pkg::stat_t        stat_updates;
    bp_pkg::stat_t        stat_mispredicts;

    logic [31:0] vec_mem [NCOL*MAX_VEC];

    int  n_vec;
    int  value_errs;
    int  other_errs;
    int  cycles;
    int  cycle_limit;
    logic running;

    predictor u_predictor (.*);

    bind predictor predictor_checker u_predictor_checker (
        .clk              (clk),
        .rstn             (rstn),
        .stall            (stall),
        .pred_valid       (pred_valid),
        .pred_npc         (pred_npc),
        .pred_kind        (pred_kind),
        .pred_taken       (pred_taken),
        .pred_use_gshare  (pred_use_gshare),
        .stat_updates     (stat_updates),
        .stat_mispredicts (stat_mispredicts)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    task automatic check_addr(input string name, input int v,
                              input bp_pkg::addr_t got, input bp_pkg::addr_t exp);
        if (got !== exp) begin
            value_errs++;
            $display("FAIL %s vector %0d: got %h expected %h", name, v, got, exp);
        end
    endtask

    task automatic check_kind(input string name, input int v,
                              input bp_pkg::branch_kind_e got, input bp_pkg::branch_kind_e exp);
        if (got !== exp) begin
            value_errs++;
            $display("FAIL %s vector %0d: got %h expected %h", name, v, got, exp);
        end
    endtask

    task automatic check_bit(input string name, input int v, input logic got, input logic exp);
        if (got !== exp) begin
            value_errs++;
            $display("FAIL %s vector %0d: got %h expected %h", name, v, got, exp);
        end
    endtask

    task automatic check_count(input string name, input int v,
                               input bp_pkg::stat_t got, input bp_pkg::stat_t exp);
        if (got !== exp) begin
            value_errs++;
            $display("FAIL %s after vector %0d: got %h expected %h", name, v, got, exp);
        end
    endtask

    task automatic clear_inputs();
        stall          = 1'b0;
        req_valid      = 1'b0;
        pc             = '0;
        upd_valid      = 1'b0;
        upd_pc         = '0;
        upd_kind       = bp_pkg::NOT_JUMP;
        upd_taken      = 1'b0;
        upd_target     = '0;
        upd_mispredict = 1'b0;
    endtask

    // outputs straight out of reset, before the first vector
    task automatic check_reset_state();
        check_bit("pred_valid", -1, pred_valid, 1'b0);
        check_addr("pred_npc", -1, pred_npc, bp_pkg::RESET_PC);
        check_kind("pred_kind", -1, pred_kind, bp_pkg::NOT_JUMP);
        check_count("stat_updates", -1, stat_updates, '0);
        check_count("stat_mispredicts", -1, stat_mispredicts, '0);
    endtask

    task automatic drive_vector(input int v);
        int b;
        b = v * NCOL;
        stall          = vec_mem[b][0];
        req_valid      = vec_mem[b+1][0];
        pc             = vec_mem[b+2][bp_pkg::ADDR_WIDTH-1:0];
        upd_valid      = vec_mem[b+3][0];
        upd_pc         = vec_mem[b+4][bp_pkg::ADDR_WIDTH-1:0];
        upd_kind       = bp_pkg::branch_kind_e'(vec_mem[b+5][2:0]);
        upd_taken      = vec_mem[b+6][0];
        upd_target     = vec_mem[b+7][bp_pkg::ADDR_WIDTH-1:0];
        upd_mispredict = vec_mem[b+8][0];
    endtask

    // prediction of vector v, one edge after it was driven
    task automatic expect_prediction(input int v);
        int b;
        b = v * NCOL;
        if (vec_mem[b+9][0]) begin
            if (pred_valid !== 1'b1) begin
                other_errs++;
                $display("vector %0d: no prediction came back, pred_valid is low", v);
            end else begin
                check_addr("pred_npc", v, pred_npc, vec_mem[b+10][bp_pkg::ADDR_WIDTH-1:0]);
                check_kind("pred_kind", v, pred_kind,
                           bp_pkg::branch_kind_e'(vec_mem[b+11][2:0]));
                check_bit("pred_taken", v, pred_taken, vec_mem[b+12][0]);
                check_bit("pred_use_gshare", v, pred_use_gshare, vec_mem[b+13][0]);
            end
        end else if (!vec_mem[b][0] && !vec_mem[b+1][0]) begin
            // idle unstalled edge drops the prediction
            check_bit("pred_valid", v, pred_valid, 1'b0);
        end
    endtask

    task automatic verify_statistics();
        bp_pkg::stat_t n_upd;
        bp_pkg::stat_t n_mis;
        n_upd = '0;
        n_mis = '0;
        for (int v = 0; v < n_vec; v++) begin
            if (vec_mem[v*NCOL+3][0]) begin
                n_upd++;
                if (vec_mem[v*NCOL+8][0]) n_mis++;
            end
        end
        check_count("stat_updates", n_vec, stat_updates, n_upd);
        check_count("stat_mispredicts", n_vec, stat_mispredicts, n_mis);
    endtask

    task automatic report_and_finish();
        $display("errors: %0d wrong values, %0d other failures", value_errs, other_errs);
        if (value_errs == 0 && other_errs == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    endtask

    initial begin
        rstn       = 1'b0;
        clear_inputs();
        value_errs = 0;
        other_errs = 0;
        running    = 1'b0;
        for (int i = 0; i < NCOL*MAX_VEC; i++) begin
            vec_mem[i] = {16'hdead, i[15:0]};  // stall column > 1 marks the end
        end
        $readmemh("verif/predictor_vectors.txt", vec_mem);
        n_vec = 0;
        while (n_vec < MAX_VEC && vec_mem[n_vec*NCOL] <= 32'd1) n_vec++;
        if (n_vec == 0) begin
            other_errs++;
            $display("no vectors could be read from the vector file");
        end
        cycle_limit = n_vec + 20;

        repeat (RST_CYCLES) @(posedge clk);
        @(negedge clk);
        check_reset_state();
        rstn    = 1'b1;
        running = 1'b1;
        for (int v = 0; v < n_vec; v++) begin
            @(negedge clk);
            if (v > 0) expect_prediction(v - 1);
            drive_vector(v);
        end
        @(negedge clk);
        if (n_vec > 0) expect_prediction(n_vec - 1);
        clear_inputs();
        verify_statistics();
        report_and_finish();
    end

    // run guard
    initial begin
        cycles = 0;
        wait (running);
        while (cycles < cycle_limit) begin
            @(posedge clk);
            cycles++;
        end
        other_errs++;
        $display("timeout: run still going after %0d cycles", cycles);
        report_and_finish();
    end

endmodule

// ==== predictor.f ====
source/bp_pkg.sv
source/bp_update_if.sv
source/kind_table.sv
source/direction_predictor.sv
source/target_predictor.sv
source/predictor.sv
verif/predictor_checker.sv
verif/tb_predictor.sv

// ==== Makefile ====
VERILATOR = verilator
VFLAGS    = --binary --timing --assert
TOP       = tb_predictor
FILELIST  = predictor.f
PASS_MSG  = ALL CHECKS PASSED

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf obj_dir

// ==== verif/predictor_vectors.txt ====
// stall req pc | upd_valid upd_pc upd_kind upd_taken upd_target upd_mispredict |
// check exp_npc exp_kind exp_taken exp_use_gshare   (hex, one line per cycle)
// cold prediction
0 1 00000100 0 00000000 0 0 00000000 0 1 00000101 0 0 0
// jump learning, same btb index with another tag misses
0 0 00000000 1 00000203 7 1 00000500 1 0 00000000 0 0 0
0 1 00000203 0 00000000 0 0 00000000 0 1 00000500 7 0 0
0 1 00000243 0 00000000 0 0 00000000 0 1 00000244 7 0 0
// counter training, first request reads before the write
0 1 00000305 1 00000305 1 1 00000700 1 1 00000306 0 0 0
0 1 00000305 1 00000305 1 1 00000700 0 1 00000700 1 1 0
0 1 00000305 1 00000305 1 1 00000700 0 1 00000700 1 1 0
0 1 00000305 0 00000000 0 0 00000000 0 1 00000700 1 1 0
// alternating pattern, chooser moves to gshare
0 0 00000000 1 00000429 1 1 00000800 1 0 00000000 0 0 0
0 1 00000429 1 00000429 1 0 00000800 1 1 00000800 1 1 0
0 0 00000000 1 00000429 1 1 00000800 1 0 00000000 0 0 0
0 1 00000429 1 00000429 1 0 00000800 0 1 0000042a 1 0 1
0 1 00000429 0 00000000 0 0 00000000 0 1 0000042a 1 0 1
// call and return
0 0 00000000 1 000000a0 6 1 00000e00 1 0 00000000 0 0 0
0 0 00000000 1 000000b1 6 1 00000f00 1 0 00000000 0 0 0
0 0 00000000 1 000000c2 4 1 00000123 1 0 00000000 0 0 0
0 1 000000a0 0 00000000 0 0 00000000 0 1 00000e00 6 0 0
0 1 000000b1 0 00000000 0 0 00000000 0 1 00000f00 6 0 0
0 1 000000c2 0 00000000 0 0 00000000 0 1 000000b2 4 0 0
0 1 000000c2 0 00000000 0 0 00000000 0 1 000000a1 4 0 0
0 1 000000c2 0 00000000 0 0 00000000 0 1 00000000 4 0 0
0 1 00000100 0 00000000 0 0 00000000 0 1 00000101 0 0 0
// stall holds the outputs, updates still land
1 1 00000203 0 00000000 0 0 00000000 0 1 00000101 0 0 0
1 0 00000000 1 00000203 7 1 00000500 0 1 00000101 0 0 0
0 1 00000203 0 00000000 0 0 00000000 0 1 00000500 7 0 0
0 0 00000000 0 00000000 0 0 00000000 0 0 00000000 0 0 0
